//--- common/sha1_pkg.sv
// SHA-1 shared types; messages arrive pre-padded and hashing always starts from the standard IV
package sha1_pkg;

	// ------------------------------
	// Plain widths
	// ------------------------------
	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [159:0] digest_t;

	// Standard initial chaining value, H0 in the top word
	localparam digest_t SHA1_IV = 160'h67452301_EFCDAB89_98BADCFE_10325476_C3D2E1F0;

	localparam int SHA1_ROUNDS = 80;
	localparam int BLOCK_WORDS = 16;
	localparam int DIGEST_BYTES = 20;

	// ------------------------------
	// Stream and engine bundles
	// ------------------------------
	typedef struct packed {
		byte_t data;
		logic sof;
		logic eof;
	} stream_beat_t;

	// Channel toward engine
	typedef struct packed {
		word_t word;
		logic word_valid;
		logic start;
		logic first_block;
	} core_req_t;

	// Engine toward channel
	typedef struct packed {
		logic busy;
		logic done;
		digest_t digest;
	} core_rsp_t;

	// Channel block sequencing
	typedef enum logic [2:0] {
		CH_IDLE,
		CH_WAIT_GNT,
		CH_LOAD,
		CH_START,
		CH_WAIT_BUSY,
		CH_WAIT_DONE,
		CH_DRAIN
	} chan_state_t;

endpackage

//--- hdl/sha1_hash_top.sv
// Multi-channel SHA-1 top; one shared round engine, so channels serialize their hashing per message
module sha1_hash_top #(
	parameter int N_CHANNELS = 2
) (
	input  logic clk,
	input  logic rst,
	input  sha1_pkg::stream_beat_t in_beat [N_CHANNELS],
	input  logic [N_CHANNELS-1:0] in_valid,
	output logic [N_CHANNELS-1:0] in_ready,
	output sha1_pkg::stream_beat_t out_beat [N_CHANNELS],
	output logic [N_CHANNELS-1:0] out_valid,
	input  logic [N_CHANNELS-1:0] out_ready
);
	import sha1_pkg::*;

	logic [N_CHANNELS-1:0] req;
	logic [N_CHANNELS-1:0] gnt;
	core_req_t chan_req [N_CHANNELS];
	core_rsp_t chan_rsp [N_CHANNELS];
	core_req_t core_req;
	core_rsp_t core_rsp;

	// One packer/serializer per stream
	for (genvar c = 0; c < N_CHANNELS; c++)
	begin : g_chan
		sha1_channel sha1_channel_i (
			.clk       (clk),
			.rst       (rst),
			.in_beat   (in_beat[c]),
			.in_valid  (in_valid[c]),
			.in_ready  (in_ready[c]),
			.out_beat  (out_beat[c]),
			.out_valid (out_valid[c]),
			.out_ready (out_ready[c]),
			.req       (req[c]),
			.gnt       (gnt[c]),
			.core_req  (chan_req[c]),
			.rsp       (chan_rsp[c])
		);
	end

	sha1_core_arbiter #(
		.N_CHANNELS (N_CHANNELS)
	) sha1_core_arbiter_i (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.chan_req (chan_req),
		.core_rsp (core_rsp),
		.gnt      (gnt),
		.core_req (core_req),
		.chan_rsp (chan_rsp)
	);

	sha1_round_engine sha1_round_engine_i (
		.clk (clk),
		.rst (rst),
		.req (core_req),
		.rsp (core_rsp)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SHA-1 testbench with Verilator from the project root
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_sha1_hash_top

verilator --binary --timing -j 0 --top-module "$TOP" \
	-f sha1_hash_top.f -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- sha1_channel/sha1_channel.sv
// SHA-1 channel; input must be pre-padded whole blocks with eof on the last byte, one message at a time
module sha1_channel (
	input  logic clk,
	input  logic rst,
	input  sha1_pkg::stream_beat_t in_beat,
	input  logic in_valid,
	output logic in_ready,
	output sha1_pkg::stream_beat_t out_beat,
	output logic out_valid,
	input  logic out_ready,
	output logic req,
	input  logic gnt,
	output sha1_pkg::core_req_t core_req,
	input  sha1_pkg::core_rsp_t rsp
);
	import sha1_pkg::*;

	localparam logic [3:0] LAST_WORD = 4'(BLOCK_WORDS - 1);
	localparam logic [4:0] LAST_BYTE = 5'(DIGEST_BYTES - 1);

	chan_state_t state;
	logic [1:0] byte_cnt;
	logic [3:0] word_cnt;
	logic [4:0] out_cnt;
	logic word_valid_q;
	logic start_q;
	logic first_q;
	logic last_q;

	// Payload
	logic [23:0] byte_sr;
	word_t word_q;
	digest_t dig_sr;

	logic in_fire;
	logic word_fire;
	logic out_fire;
	logic dig_load;

	assign in_ready = gnt && (state == CH_LOAD) && !rsp.busy;
	assign in_fire = in_valid && in_ready;
	assign word_fire = in_fire && (byte_cnt == 2'd3);
	assign out_valid = (state == CH_DRAIN);
	assign out_fire = out_valid && out_ready;
	assign dig_load = (state == CH_WAIT_DONE) && rsp.done && last_q;

	// ------------------------------
	// Block sequencing
	// ------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= CH_IDLE;
			byte_cnt <= '0;
			word_cnt <= '0;
			out_cnt <= '0;
			word_valid_q <= 1'b0;
			start_q <= 1'b0;
			first_q <= 1'b0;
			last_q <= 1'b0;
			req <= 1'b0;
		end
		else
		begin
			word_valid_q <= word_fire;
			start_q <= 1'b0;
			case (state)
				CH_IDLE:
				begin
					if (in_valid)
					begin
						req <= 1'b1;
						first_q <= 1'b1;
						last_q <= 1'b0;
						byte_cnt <= '0;
						word_cnt <= '0;
						state <= CH_WAIT_GNT;
					end
				end
				CH_WAIT_GNT:
				begin
					if (gnt)
						state <= CH_LOAD;
				end
				CH_LOAD:
				begin
					if (in_fire)
					begin
						byte_cnt <= byte_cnt + 2'd1;
						if (in_beat.eof)
							last_q <= 1'b1;
					end
					if (word_fire)
					begin
						word_cnt <= word_cnt + 4'd1;
						if (word_cnt == LAST_WORD)
							state <= CH_START;
					end
				end
				CH_START:
				begin
					// Sixteenth word goes out this cycle, start right after
					start_q <= 1'b1;
					state <= CH_WAIT_BUSY;
				end
				CH_WAIT_BUSY:
				begin
					if (rsp.busy)
						state <= CH_WAIT_DONE;
				end
				CH_WAIT_DONE:
				begin
					if (rsp.done)
					begin
						first_q <= 1'b0;
						if (last_q)
						begin
							// Release the engine before draining
							req <= 1'b0;
							out_cnt <= '0;
							state <= CH_DRAIN;
						end
						else
							state <= CH_LOAD;
					end
				end
				CH_DRAIN:
				begin
					if (out_fire)
					begin
						out_cnt <= out_cnt + 5'd1;
						if (out_cnt == LAST_BYTE)
							state <= CH_IDLE;
					end
				end
				default: state <= CH_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Packing and digest shift
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (in_fire)
			byte_sr <= {byte_sr[15:0], in_beat.data};
		// Big-endian, first byte lands on top
		if (word_fire)
			word_q <= {byte_sr, in_beat.data};
		if (dig_load)
			dig_sr <= rsp.digest;
		else if (out_fire)
			dig_sr <= {dig_sr[151:0], 8'h00};
	end

	always_comb
	begin
		out_beat.data = dig_sr[159:152];
		out_beat.sof = (out_cnt == '0);
		out_beat.eof = (out_cnt == LAST_BYTE);

		core_req.word = word_q;
		core_req.word_valid = word_valid_q;
		core_req.start = start_q;
		core_req.first_block = first_q;
	end

endmodule

//--- sha1_core/sha1_core_arbiter.sv
// Round-robin engine arbiter; a grant lasts until the owner drops req, so it spans a whole message
module sha1_core_arbiter #(
	parameter int N_CHANNELS = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic [N_CHANNELS-1:0] req,
	input  sha1_pkg::core_req_t chan_req [N_CHANNELS],
	input  sha1_pkg::core_rsp_t core_rsp,
	output logic [N_CHANNELS-1:0] gnt,
	output sha1_pkg::core_req_t core_req,
	output sha1_pkg::core_rsp_t chan_rsp [N_CHANNELS]
);
	localparam int IDX_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

	logic [IDX_W-1:0] ptr;
	logic [IDX_W-1:0] pick_idx;
	logic [N_CHANNELS-1:0] pick;
	logic pick_any;

	// First active request at or after the pointer
	always_comb
	begin
		int cand;
		pick = '0;
		pick_idx = '0;
		pick_any = 1'b0;
		for (int i = 0; i < N_CHANNELS; i++)
		begin
			cand = int'(ptr) + i;
			if (cand >= N_CHANNELS)
				cand = cand - N_CHANNELS;
			if (!pick_any && req[cand])
			begin
				pick_any = 1'b1;
				pick[cand] = 1'b1;
				pick_idx = IDX_W'(cand);
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			gnt <= '0;
			ptr <= '0;
		end
		else if (gnt == '0)
		begin
			if (pick_any)
			begin
				gnt <= pick;
				ptr <= (int'(pick_idx) == N_CHANNELS - 1) ? '0 : pick_idx + 1'b1;
			end
		end
		else if ((gnt & req) == '0)
			gnt <= '0;
	end

	// ------------------------------
	// Request mux, response gating
	// ------------------------------
	always_comb
	begin
		core_req = '0;
		for (int c = 0; c < N_CHANNELS; c++)
			if (gnt[c])
				core_req = chan_req[c];
	end

	always_comb
	begin
		for (int c = 0; c < N_CHANNELS; c++)
		begin
			chan_rsp[c] = core_rsp;
			// Losers see a permanently busy engine
			if (!gnt[c])
			begin
				chan_rsp[c].busy = 1'b1;
				chan_rsp[c].done = 1'b0;
			end
		end
	end

endmodule

//--- sha1_core/sha1_round_engine.sv
// SHA-1 compression, one round per clock; words must only be written while busy is low
module sha1_round_engine (
	input  logic clk,
	input  logic rst,
	input  sha1_pkg::core_req_t req,
	output sha1_pkg::core_rsp_t rsp
);
	import sha1_pkg::*;

	typedef enum logic {
		ENG_IDLE,
		ENG_ROUND
	} eng_state_t;

	// Round constants per group of 20
	localparam word_t K0 = 32'h5A827999;
	localparam word_t K1 = 32'h6ED9EBA1;
	localparam word_t K2 = 32'h8F1BBCDC;
	localparam word_t K3 = 32'hCA62C1D6;
	localparam logic [6:0] LAST_ROUND = 7'(SHA1_ROUNDS - 1);

	eng_state_t state;
	logic [6:0] round;
	logic [3:0] wr_idx;
	logic done_q;

	// Block buffer doubles as the schedule window
	word_t blk [BLOCK_WORDS];
	word_t a, b, c, d, e;
	digest_t cv;

	word_t f_val;
	word_t k_val;
	word_t w_mix;
	word_t w_next;
	word_t t_val;
	word_t b_rot;

	// ------------------------------
	// Round function
	// ------------------------------
	always_comb
	begin
		if (round < 7'd20)
		begin
			f_val = (b & c) | (~b & d);
			k_val = K0;
		end
		else if (round < 7'd40)
		begin
			f_val = b ^ c ^ d;
			k_val = K1;
		end
		else if (round < 7'd60)
		begin
			f_val = (b & c) | (b & d) | (c & d);
			k_val = K2;
		end
		else
		begin
			f_val = b ^ c ^ d;
			k_val = K3;
		end

		// W[t+16] from the window positions t+13, t+8, t+2, t
		w_mix = blk[13] ^ blk[8] ^ blk[2] ^ blk[0];
		w_next = {w_mix[30:0], w_mix[31]};

		t_val = {a[26:0], a[31:27]} + f_val + e + k_val + blk[0];
		b_rot = {b[1:0], b[31:2]};
	end

	// ------------------------------
	// Control
	// ------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ENG_IDLE;
			round <= '0;
			wr_idx <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				ENG_IDLE:
				begin
					if (req.word_valid)
						wr_idx <= wr_idx + 4'd1;
					if (req.start)
					begin
						state <= ENG_ROUND;
						round <= '0;
						wr_idx <= '0;
					end
				end
				ENG_ROUND:
				begin
					round <= round + 7'd1;
					if (round == LAST_ROUND)
					begin
						state <= ENG_IDLE;
						done_q <= 1'b1;
					end
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Datapath
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (state == ENG_IDLE)
		begin
			if (req.word_valid)
				blk[wr_idx] <= req.word;
			if (req.start)
			begin
				// New message restarts the chain from the IV
				if (req.first_block)
				begin
					{a, b, c, d, e} <= SHA1_IV;
					cv <= SHA1_IV;
				end
				else
					{a, b, c, d, e} <= cv;
			end
		end
		else
		begin
			for (int i = 0; i < BLOCK_WORDS - 1; i++)
				blk[i] <= blk[i + 1];
			blk[BLOCK_WORDS - 1] <= w_next;

			a <= t_val;
			b <= a;
			c <= b_rot;
			d <= c;
			e <= d;

			// Fold the final working variables into the chain
			if (round == LAST_ROUND)
			begin
				cv[159:128] <= cv[159:128] + t_val;
				cv[127:96] <= cv[127:96] + a;
				cv[95:64] <= cv[95:64] + b_rot;
				cv[63:32] <= cv[63:32] + c;
				cv[31:0] <= cv[31:0] + d;
			end
		end
	end

	always_comb
	begin
		rsp.busy = (state == ENG_ROUND);
		rsp.done = done_q;
		rsp.digest = cv;
	end

endmodule

//--- sha1_hash_top.f
+incdir+verification
common/sha1_pkg.sv
sha1_core/sha1_round_engine.sv
sha1_core/sha1_core_arbiter.sv
sha1_channel/sha1_channel.sv
hdl/sha1_hash_top.sv
verification/tb_sha1_hash_top.sv

//--- verification/sha1_model.svh
// Reference SHA-1 for the testbench; include inside a module body, hashes whole padded blocks only
`ifndef SHA1_MODEL_SVH
`define SHA1_MODEL_SVH

function automatic logic [31:0] rotate_left(input logic [31:0] x, input int n);
	return (x << n) | (x >> (32 - n));
endfunction

// Append 0x80, zero fill up to 56 mod 64, then the 64-bit bit length
function automatic void pad_message(input logic [7:0] raw[$], output logic [7:0] padded[$]);
	logic [63:0] bit_len;
	padded = raw;
	bit_len = 64'(raw.size()) * 64'd8;
	padded.push_back(8'h80);
	while (padded.size() % 64 != 56)
		padded.push_back(8'h00);
	for (int i = 7; i >= 0; i--)
		padded.push_back(bit_len[8 * i +: 8]);
endfunction

// ------------------------------
// FIPS 180 compression, full schedule
// ------------------------------
function automatic logic [159:0] sha1_digest(input logic [7:0] msg[$]);
	logic [31:0] h [5];
	logic [31:0] w [80];
	logic [31:0] a, b, c, d, e, f, k, tmp;
	int base;
	h[0] = 32'h67452301;
	h[1] = 32'hEFCDAB89;
	h[2] = 32'h98BADCFE;
	h[3] = 32'h10325476;
	h[4] = 32'hC3D2E1F0;
	for (int blk = 0; blk < msg.size() / 64; blk++)
	begin
		base = blk * 64;
		for (int t = 0; t < 16; t++)
			w[t] = {msg[base + 4 * t], msg[base + 4 * t + 1],
				msg[base + 4 * t + 2], msg[base + 4 * t + 3]};
		for (int t = 16; t < 80; t++)
			w[t] = rotate_left(w[t - 3] ^ w[t - 8] ^ w[t - 14] ^ w[t - 16], 1);
		a = h[0];
		b = h[1];
		c = h[2];
		d = h[3];
		e = h[4];
		for (int t = 0; t < 80; t++)
		begin
			if (t < 20)
			begin
				f = (b & c) | (~b & d);
				k = 32'h5A827999;
			end
			else if (t < 40)
			begin
				f = b ^ c ^ d;
				k = 32'h6ED9EBA1;
			end
			else if (t < 60)
			begin
				f = (b & c) | (b & d) | (c & d);
				k = 32'h8F1BBCDC;
			end
			else
			begin
				f = b ^ c ^ d;
				k = 32'hCA62C1D6;
			end
			tmp = rotate_left(a, 5) + f + e + k + w[t];
			e = d;
			d = c;
			c = rotate_left(b, 30);
			b = a;
			a = tmp;
		end
		h[0] += a;
		h[1] += b;
		h[2] += c;
		h[3] += d;
		h[4] += e;
	end
	return {h[0], h[1], h[2], h[3], h[4]};
endfunction

`endif

//--- verification/tb_sha1_hash_top.sv
// Testbench for two channels; stops at the first error, random stimulus from seed 27
module tb_sha1_hash_top;
	import sha1_pkg::*;

	`include "sha1_model.svh"

	localparam int N_MULTI = 3;
	localparam int N_SHARED = 3;
	localparam int N_BP = 3;
	localparam int MAX_BLOCKS = 4;
	localparam int CH0_DIGESTS = 1 + N_SHARED + N_BP;
	localparam int CH1_DIGESTS = N_MULTI + N_SHARED + N_BP;
	// Upper bound on blocks, slack for back-pressure per digest
	localparam int TIMEOUT_CYCLES = (CH0_DIGESTS + CH1_DIGESTS) * MAX_BLOCKS * 200
		+ (CH0_DIGESTS + CH1_DIGESTS) * 100 + 50;

	logic clk;
	logic rst;
	stream_beat_t in_beat [2];
	logic [1:0] in_valid;
	logic [1:0] in_ready;
	stream_beat_t out_beat [2];
	logic [1:0] out_valid;
	logic [1:0] out_ready;

	int seed;
	int cycles = 0;
	logic bp_on = 1'b0;
	string test_name = "reset";
	logic [159:0] exp_q [2][$];

	sha1_hash_top #(
		.N_CHANNELS (2)
	) sha1_hash_top_i (
		.clk       (clk),
		.rst       (rst),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fffffff) % n;
	endfunction

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("Timeout: run still going after %0d cycles", cycles));
	end

	// Roughly 30 % of cycles stall the output when back-pressure is on
	initial
	begin
		out_ready = 2'b00;
		forever
		begin
			@(posedge clk);
			#1;
			for (int ch = 0; ch < 2; ch++)
				out_ready[ch] = bp_on ? (rand_below(100) >= 30) : 1'b1;
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic send_message(input int ch, input logic [7:0] msg[$], input int gap_pct);
		logic accepted;
		for (int i = 0; i < msg.size(); i++)
		begin
			while (rand_below(100) < gap_pct)
			begin
				in_valid[ch] = 1'b0;
				@(posedge clk);
				#1;
			end
			in_beat[ch].data = msg[i];
			in_beat[ch].sof = (i == 0);
			in_beat[ch].eof = (i == msg.size() - 1);
			in_valid[ch] = 1'b1;
			accepted = 1'b0;
			// Handshake sampled mid-cycle, transfer lands on the next rising edge
			while (!accepted)
			begin
				@(negedge clk);
				accepted = in_ready[ch];
				@(posedge clk);
				#1;
			end
		end
		in_valid[ch] = 1'b0;
	endtask

	task automatic run_channel(input int ch, input int n_msgs, input int min_blk,
		input int max_blk, input int gap_pct);
		logic [7:0] raw[$];
		logic [7:0] padded[$];
		int nblk;
		int len;
		for (int m = 0; m < n_msgs; m++)
		begin
			nblk = min_blk + rand_below(max_blk - min_blk + 1);
			len = (nblk - 1) * 64 + rand_below(56);
			raw.delete();
			for (int i = 0; i < len; i++)
				raw.push_back(8'($random(seed)));
			pad_message(raw, padded);
			exp_q[ch].push_back(sha1_digest(padded));
			send_message(ch, padded, gap_pct);
		end
	endtask

	task automatic wait_drained();
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0
			|| g_mon[0].byte_idx != 0 || g_mon[1].byte_idx != 0)
			@(posedge clk);
		#1;
	endtask

	task automatic check_quiet_outputs();
		assert (in_ready == 2'b00 && out_valid == 2'b00)
		else stop_on_error("in_ready or out_valid high during or right after reset");
	endtask

	// ------------------------------
	// Output monitors
	// ------------------------------
	for (genvar g = 0; g < 2; g++)
	begin : g_mon
		int byte_idx = 0;
		logic stalled = 1'b0;
		stream_beat_t held;
		logic [159:0] cur_dig;
		logic [7:0] exp_byte;

		always @(negedge clk)
		begin
			if (!rst)
			begin
				if (stalled)
					assert (out_valid[g] && out_beat[g] == held)
					else stop_on_error($sformatf(
						"Channel %0d changed its output beat while out_ready was low", g));
				if (out_valid[g] && out_ready[g])
				begin
					if (byte_idx == 0)
					begin
						assert (exp_q[g].size() != 0)
						else stop_on_error($sformatf(
							"Channel %0d sent a digest with no message pending", g));
						cur_dig = exp_q[g].pop_front();
					end
					exp_byte = cur_dig[159 - 8 * byte_idx -: 8];
					assert (out_beat[g].data == exp_byte)
					else stop_on_error($sformatf(
						"Mismatch: test %s, channel %0d byte %0d, expected %02h, actual %02h",
						test_name, g, byte_idx, exp_byte, out_beat[g].data));
					assert (out_beat[g].sof == (byte_idx == 0) && out_beat[g].eof == (byte_idx == 19))
					else stop_on_error($sformatf(
						"Channel %0d has wrong sof or eof on digest byte %0d", g, byte_idx));
					if (byte_idx == 19)
						byte_idx = 0;
					else
						byte_idx++;
				end
				stalled = out_valid[g] && !out_ready[g];
				held = out_beat[g];
			end
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		logic [7:0] raw[$];
		logic [7:0] padded[$];
		logic [159:0] abc_dig;
		seed = 27;
		rst = 1'b1;
		in_valid = 2'b00;
		in_beat[0] = '0;
		in_beat[1] = '0;
		repeat (8)
		begin
			@(negedge clk);
			check_quiet_outputs();
		end
		@(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_quiet_outputs();
		@(posedge clk);
		#1;

		test_name = "single_block";
		raw = '{8'h61, 8'h62, 8'h63};
		pad_message(raw, padded);
		abc_dig = sha1_digest(padded);
		assert (abc_dig == 160'ha9993e364706816aba3e25717850c26c9cd0d89d)
		else stop_on_error($sformatf(
			"Mismatch: test %s, model, expected %h, actual %h", test_name,
			160'ha9993e364706816aba3e25717850c26c9cd0d89d, abc_dig));
		exp_q[0].push_back(abc_dig);
		send_message(0, padded, 0);
		wait_drained();

		test_name = "multi_block";
		run_channel(1, N_MULTI, 2, MAX_BLOCKS, 0);
		wait_drained();

		test_name = "shared_engine";
		fork
			run_channel(0, N_SHARED, 1, 3, 0);
			run_channel(1, N_SHARED, 1, 3, 0);
		join
		wait_drained();

		test_name = "backpressure";
		bp_on = 1'b1;
		fork
			run_channel(0, N_BP, 1, 3, 30);
			run_channel(1, N_BP, 1, 3, 30);
		join
		wait_drained();

		// Channels go idle the cycle after their last digest byte
		if (out_valid == 2'b00)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			stop_on_error("Output still valid after the last digest was drained");
	end

endmodule
